/* Makefile */
TOP := camera_capture_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  -f camera_capture.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* camera_capture.f */
logic/camera_pkg.sv
logic/stream_ifs.sv
logic/pixel_reconstruct.sv
logic/frame_downsampler.sv
logic/pixel_stacker.sv
logic/chunk_fifo.sv
logic/camera_capture_top.sv
verification/camera_capture_props.sv
verification/camera_capture_tb.sv

/* logic/camera_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_capture_top import camera_pkg::*; #(
  parameter int HRES             = 1280,
  parameter int VRES             = 720,
  parameter int CHUNK_FIFO_DEPTH = 4
) (
  input  logic       clk_camera,
  input  logic       sys_rst_camera,
  input  logic [7:0] camera_d,
  input  logic       cam_pclk,
  input  logic       cam_hsync,
  input  logic       cam_vsync,
  input  logic       chunk_tready,
  output logic       chunk_tvalid,
  output chunk_t     chunk_tdata,
  output logic       chunk_tlast,
  output logic       overflow
);

  // full-resolution pixel strobe
  logic    pixel_valid;
  pixel_t  pixel;
  hcount_t hcount;
  vcount_t vcount;

  pixel_stream_if pixel_bus ();  // kept pixels
  chunk_stream_if chunk_bus ();  // packed chunks into the FIFO

  pixel_reconstruct #(.HRES(HRES), .VRES(VRES)) pixel_reconstruct_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .camera_d       (camera_d),
    .cam_pclk       (cam_pclk),
    .cam_hsync      (cam_hsync),
    .cam_vsync      (cam_vsync),
    .pixel_valid    (pixel_valid),
    .pixel          (pixel),
    .hcount         (hcount),
    .vcount         (vcount)
  );

  // 2x2 decimation
  frame_downsampler #(.HRES(HRES), .VRES(VRES)) frame_downsampler_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pixel_valid    (pixel_valid),
    .pixel          (pixel),
    .hcount         (hcount),
    .vcount         (vcount),
    .pixel_out      (pixel_bus.source)
  );

  pixel_stacker pixel_stacker_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pixel_in       (pixel_bus.sink),
    .chunk_out      (chunk_bus.source),
    .overflow       (overflow)
  );

  chunk_fifo #(.CHUNK_FIFO_DEPTH(CHUNK_FIFO_DEPTH)) chunk_fifo_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .chunk_in       (chunk_bus.sink),
    .out_valid      (chunk_tvalid),
    .out_data       (chunk_tdata),
    .out_last       (chunk_tlast),
    .out_ready      (chunk_tready)
  );

endmodule

`default_nettype wire

/* logic/camera_pkg.sv */
`default_nettype none

package camera_pkg;

  // pixel and count widths
  localparam int PIXEL_BITS  = 8;   // luminance only
  localparam int HCOUNT_BITS = 11;
  localparam int VCOUNT_BITS = 10;

  // chunk geometry, one 128-bit memory word
  localparam int PIXELS_PER_CHUNK = 16;
  localparam int CHUNK_BITS       = PIXEL_BITS * PIXELS_PER_CHUNK;
  localparam int CHUNK_COUNT_BITS = $clog2(PIXELS_PER_CHUNK);  // fill counter width

  typedef logic [PIXEL_BITS-1:0]  pixel_t;
  typedef logic [HCOUNT_BITS-1:0] hcount_t;
  typedef logic [VCOUNT_BITS-1:0] vcount_t;

  // first pixel accepted sits in bits [7:0]
  typedef logic [CHUNK_BITS-1:0] chunk_t;

endpackage

`default_nettype wire

/* logic/chunk_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_fifo import camera_pkg::*; #(
  parameter int CHUNK_FIFO_DEPTH = 4
) (
  input  logic         clk_camera,
  input  logic         sys_rst_camera,
  chunk_stream_if.sink chunk_in,
  output logic         out_valid,
  output chunk_t       out_data,
  output logic         out_last,
  input  logic         out_ready
);

  localparam int PTR_W = (CHUNK_FIFO_DEPTH > 1) ? $clog2(CHUNK_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(CHUNK_FIFO_DEPTH + 1);

  chunk_t           mem_data [CHUNK_FIFO_DEPTH];
  logic             mem_last [CHUNK_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] used;   // occupancy
  logic             push;
  logic             pop;

  // wraps at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(CHUNK_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign chunk_in.ready = (used != CNT_W'(CHUNK_FIFO_DEPTH));
  assign out_valid      = (used != '0);
  assign push           = chunk_in.valid & chunk_in.ready;
  assign pop            = out_valid & out_ready;

  // head entry shown straight from storage
  assign out_data = mem_data[rd_ptr];
  assign out_last = mem_last[rd_ptr];

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;  // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_camera) begin
    if (push) begin
      mem_data[wr_ptr] <= chunk_in.data;
      mem_last[wr_ptr] <= chunk_in.last;
    end
  end

endmodule

`default_nettype wire

/* logic/frame_downsampler.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_downsampler import camera_pkg::*; #(
  parameter int HRES = 1280,
  parameter int VRES = 720
) (
  input  logic           clk_camera,
  input  logic           sys_rst_camera,
  input  logic           pixel_valid,
  input  pixel_t         pixel,
  input  hcount_t        hcount,
  input  vcount_t        vcount,
  pixel_stream_if.source pixel_out
);

  // last kept pixel sits on the last even column of the last even row
  localparam hcount_t LAST_H = hcount_t'(HRES - 2);
  localparam vcount_t LAST_V = vcount_t'(VRES - 2);

  logic keep;
  logic at_end;

  assign keep   = pixel_valid & ~hcount[0] & ~vcount[0];  // even row and column
  assign at_end = (hcount == LAST_H) && (vcount == LAST_V);

  // no wait on ready, the camera keeps going regardless
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pixel_out.valid <= 1'b0;
      pixel_out.last  <= 1'b0;
    end else begin
      pixel_out.valid <= keep;
      pixel_out.last  <= keep & at_end;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (keep) begin
      pixel_out.data <= pixel;
    end
  end

endmodule

`default_nettype wire

/* logic/pixel_reconstruct.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct import camera_pkg::*; #(
  parameter int HRES = 1280,
  parameter int VRES = 720
) (
  input  logic       clk_camera,
  input  logic       sys_rst_camera,
  input  logic [7:0] camera_d,
  input  logic       cam_pclk,
  input  logic       cam_hsync,
  input  logic       cam_vsync,
  output logic       pixel_valid,
  output pixel_t     pixel,
  output hcount_t    hcount,
  output vcount_t    vcount
);

  localparam hcount_t H_MAX = hcount_t'(HRES - 1);
  localparam vcount_t V_MAX = vcount_t'(VRES - 1);

  // two-flop synchronizers with index 1 as the settled stage
  logic [1:0][7:0] d_sync;
  logic [1:0]      pclk_sync;
  logic [1:0]      hsync_sync;
  logic [1:0]      vsync_sync;

  logic    pclk_prev;
  logic    hsync_prev;
  logic    pclk_rise;
  logic    hsync_fall;
  logic    pixel_take;
  hcount_t h_cnt;     // position of the next pixel in the line
  vcount_t v_cnt;

  // camera byte synchronizer
  always_ff @(posedge clk_camera) begin
    d_sync <= {d_sync[0], camera_d};
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
      pclk_prev  <= 1'b0;
      hsync_prev <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk};
      hsync_sync <= {hsync_sync[0], cam_hsync};
      vsync_sync <= {vsync_sync[0], cam_vsync};
      pclk_prev  <= pclk_sync[1];
      hsync_prev <= hsync_sync[1];
    end
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
  assign hsync_fall = hsync_prev & ~hsync_sync[1];
  assign pixel_take = pclk_rise & hsync_sync[1];  // active line only

  // line and frame position
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (vsync_sync[1]) begin
      h_cnt <= '0;   // frame start
      v_cnt <= '0;
    end else if (hsync_fall) begin
      h_cnt <= '0;
      if (v_cnt != V_MAX) begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else if (pixel_take) begin
      if (h_cnt != H_MAX) begin  // hold at the edge on an overlong line
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      pixel_valid <= 1'b0;
      hcount      <= '0;
      vcount      <= '0;
    end else begin
      pixel_valid <= pixel_take;  // single-cycle strobe
      if (pixel_take) begin
        hcount <= h_cnt;
        vcount <= v_cnt;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pixel_take) begin
      pixel <= d_sync[1];
    end
  end

endmodule

`default_nettype wire

/* logic/pixel_stacker.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_stacker import camera_pkg::*; (
  input  logic           clk_camera,
  input  logic           sys_rst_camera,
  pixel_stream_if.sink   pixel_in,
  chunk_stream_if.source chunk_out,
  output logic           overflow
);

  localparam logic [CHUNK_COUNT_BITS-1:0] FILL_LAST =
    CHUNK_COUNT_BITS'(PIXELS_PER_CHUNK - 1);

  logic [CHUNK_COUNT_BITS-1:0] fill;  // pixels already in chunk_reg
  chunk_t chunk_reg;
  logic   chunk_last;
  logic   chunk_valid;
  logic   take;
  logic   handoff;

  // full chunk waiting blocks new pixels
  assign pixel_in.ready = ~chunk_valid;
  assign take           = pixel_in.valid & pixel_in.ready;
  assign handoff        = chunk_out.valid & chunk_out.ready;

  assign chunk_out.valid = chunk_valid;
  assign chunk_out.data  = chunk_reg;
  assign chunk_out.last  = chunk_last;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      fill        <= '0;
      chunk_valid <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      if (take) begin
        if (fill == FILL_LAST) begin
          fill        <= '0;
          chunk_valid <= 1'b1;  // offer on the next cycle
        end else begin
          fill <= fill + 1'b1;
        end
      end else if (handoff) begin
        chunk_valid <= 1'b0;
      end
      // sticky until reset
      if (pixel_in.valid && !pixel_in.ready) begin
        overflow <= 1'b1;
      end
    end
  end

  // shift right so the oldest pixel ends up in the low byte
  always_ff @(posedge clk_camera) begin
    if (take) begin
      chunk_reg  <= {pixel_in.data, chunk_reg[CHUNK_BITS-1:PIXEL_BITS]};
      chunk_last <= pixel_in.last;  // 16th pixel's flag wins
    end
  end

endmodule

`default_nettype wire

/* logic/stream_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// decimated pixels, downsampler to stacker
interface pixel_stream_if import camera_pkg::*; ();
  logic   valid;
  logic   ready;  // low drops the pixel, source never waits
  pixel_t data;
  logic   last;   // final kept pixel of the frame

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );
endinterface

// full valid/ready, data and last hold until taken
interface chunk_stream_if import camera_pkg::*; ();
  logic   valid;
  logic   ready;
  chunk_t data;
  logic   last;   // final chunk of the frame

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );
endinterface

`default_nettype wire

/* verification/camera_capture_props.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_capture_props import camera_pkg::*; (
  input logic   clk_camera,
  input logic   sys_rst_camera,
  input logic   chunk_tvalid,
  input logic   chunk_tready,
  input chunk_t chunk_tdata,
  input logic   chunk_tlast,
  input logic   overflow
);

  // FIFO comes out of reset empty
  valid_low_after_reset: assert property (
    @(posedge clk_camera) sys_rst_camera |=> !chunk_tvalid
  ) else $error("chunk_tvalid high in the cycle after reset");

  // offered chunk holds until taken
  output_held_under_stall: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
      chunk_tvalid && !chunk_tready |=>
        chunk_tvalid && $stable(chunk_tdata) && $stable(chunk_tlast)
  ) else $error("chunk output changed while chunk_tready was low");

  overflow_sticky: assert property (
    @(posedge clk_camera) disable iff (sys_rst_camera)
      !$past(sys_rst_camera) |-> !$fell(overflow)
  ) else $error("overflow fell outside reset");

endmodule

bind camera_capture_top camera_capture_props props_inst (
  .clk_camera     (clk_camera),
  .sys_rst_camera (sys_rst_camera),
  .chunk_tvalid   (chunk_tvalid),
  .chunk_tready   (chunk_tready),
  .chunk_tdata    (chunk_tdata),
  .chunk_tlast    (chunk_tlast),
  .overflow       (overflow)
);

`default_nettype wire

/* verification/camera_capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_capture_tb import camera_pkg::*; ();

  localparam int HRES             = 64;
  localparam int VRES             = 8;
  localparam int CHUNK_FIFO_DEPTH = 4;
  localparam int LINE_GAP         = 8;   // pclk cycles with hsync low
  localparam int VSYNC_PCLKS      = 4;
  localparam int PCLK_DIV         = 4;   // clk_camera cycles per pclk
  localparam int CHUNKS_PER_FRAME = (HRES / 2) * (VRES / 2) / PIXELS_PER_CHUNK;
  localparam int CHECKED_FRAMES   = 4;
  localparam int NUM_FRAMES       = 5;   // the last one runs stalled
  localparam int FRAME_CYCLES     = (VSYNC_PCLKS + VRES * (HRES + LINE_GAP)) * PCLK_DIV;

  localparam logic [1:0] READY_LOW    = 2'd0;
  localparam logic [1:0] READY_HIGH   = 2'd1;
  localparam logic [1:0] READY_RANDOM = 2'd2;

  logic       clk_camera;
  logic       sys_rst_camera;
  logic [7:0] camera_d;
  logic       cam_pclk;
  logic       cam_hsync;
  logic       cam_vsync;
  logic       chunk_tready;
  logic       chunk_tvalid;
  chunk_t     chunk_tdata;
  logic       chunk_tlast;
  logic       overflow;

  pixel_t     frame_pix [CHECKED_FRAMES][HRES*VRES];  // bytes as sent, per frame
  logic [7:0] pix_lfsr;
  logic [7:0] rdy_lfsr;
  logic [1:0] ready_mode;
  logic       compare_en;
  logic       stall_watch;   // tready held low, tvalid must not drop
  logic       tvalid_seen;
  int         rx_chunks;
  int         mismatch_count;
  int         fail_count;

  camera_capture_top #(
    .HRES             (HRES),
    .VRES             (VRES),
    .CHUNK_FIFO_DEPTH (CHUNK_FIFO_DEPTH)
  ) uut (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .camera_d       (camera_d),
    .cam_pclk       (cam_pclk),
    .cam_hsync      (cam_hsync),
    .cam_vsync      (cam_vsync),
    .chunk_tready   (chunk_tready),
    .chunk_tvalid   (chunk_tvalid),
    .chunk_tdata    (chunk_tdata),
    .chunk_tlast    (chunk_tlast),
    .overflow       (overflow)
  );

  always #5 clk_camera = ~clk_camera;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic next_pixel_byte(output pixel_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      pix_lfsr = lfsr_step(pix_lfsr);
      b = {b[6:0], pix_lfsr[0]};  // one step per bit
    end
  endtask

  // even rows and columns in raster order, first pixel in the low byte
  function automatic chunk_t expected_chunk(input int f, input int k);
    chunk_t c;
    int     n;
    int     row;
    int     col;
    c = '0;
    for (int i = 0; i < PIXELS_PER_CHUNK; i++) begin
      n   = k * PIXELS_PER_CHUNK + i;
      row = 2 * (n / (HRES / 2));
      col = 2 * (n % (HRES / 2));
      c[i*8 +: 8] = frame_pix[f][row*HRES + col];
    end
    return c;
  endfunction

  // one pclk period, data changes with the falling edge
  task automatic pclk_cycle(input pixel_t d, input logic hs, input logic vs);
    @(posedge clk_camera);
    #1;
    cam_pclk  = 1'b0;
    camera_d  = d;
    cam_hsync = hs;
    cam_vsync = vs;
    @(posedge clk_camera);
    @(posedge clk_camera);
    #1;
    cam_pclk = 1'b1;
    @(posedge clk_camera);
  endtask

  task automatic send_frame(input int f);
    pixel_t b;
    for (int i = 0; i < VSYNC_PCLKS; i++) begin
      pclk_cycle(8'h00, 1'b0, 1'b1);
    end
    for (int y = 0; y < VRES; y++) begin
      for (int x = 0; x < HRES; x++) begin
        next_pixel_byte(b);
        if (f < CHECKED_FRAMES) begin
          frame_pix[f][y*HRES + x] = b;
        end
        pclk_cycle(b, 1'b1, 1'b0);
      end
      for (int g = 0; g < LINE_GAP; g++) begin
        pclk_cycle(8'h00, 1'b0, 1'b0);  // horizontal blanking
      end
    end
  endtask

  always @(posedge clk_camera) begin
    #1;
    case (ready_mode)
      READY_LOW:  chunk_tready = 1'b0;
      READY_HIGH: chunk_tready = 1'b1;
      default: begin
        rdy_lfsr     = lfsr_step(rdy_lfsr);
        chunk_tready = rdy_lfsr[0];
      end
    endcase
  end

  // compare every accepted chunk with the reference
  always @(posedge clk_camera) begin
    chunk_t exp_data;
    logic   exp_last;
    int     f;
    int     k;
    f = rx_chunks / CHUNKS_PER_FRAME;
    k = rx_chunks % CHUNKS_PER_FRAME;
    if (!sys_rst_camera && chunk_tvalid && chunk_tready) begin
      if (compare_en && f >= CHECKED_FRAMES) begin
        fail_count++;
        $display("unexpected extra chunk after %0d frames", CHECKED_FRAMES);
      end else if (compare_en) begin
        exp_data = expected_chunk(f, k);
        exp_last = (k == CHUNKS_PER_FRAME - 1);
        if (chunk_tdata !== exp_data) begin
          mismatch_count++;
          $display("MISMATCH chunk_tdata frame %0d chunk %0d: got %h expected %h",
                   f, k, chunk_tdata, exp_data);
        end
        if (chunk_tlast !== exp_last) begin
          mismatch_count++;
          $display("MISMATCH chunk_tlast frame %0d chunk %0d: got %h expected %h",
                   f, k, chunk_tlast, exp_last);
        end
      end
      rx_chunks++;
    end
    if (stall_watch) begin
      if (chunk_tvalid) begin
        tvalid_seen = 1'b1;
      end else if (tvalid_seen) begin
        fail_count++;
        $display("chunk_tvalid dropped while chunk_tready was held low");
      end
    end
  end

  initial begin
    repeat (NUM_FRAMES * FRAME_CYCLES * 2) @(posedge clk_camera);
    $display("watchdog expired, the DUT stopped delivering chunks");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    clk_camera     = 1'b0;
    sys_rst_camera = 1'b1;
    camera_d       = 8'h00;
    cam_pclk       = 1'b0;
    cam_hsync      = 1'b0;
    cam_vsync      = 1'b0;
    chunk_tready   = 1'b1;
    ready_mode     = READY_HIGH;
    pix_lfsr       = 8'd97;
    rdy_lfsr       = 8'd97;
    compare_en     = 1'b1;
    stall_watch    = 1'b0;
    tvalid_seen    = 1'b0;
    rx_chunks      = 0;
    mismatch_count = 0;
    fail_count     = 0;
    repeat (5) @(posedge clk_camera);
    #1;
    sys_rst_camera = 1'b0;

    // idle outputs right after reset
    repeat (20) begin
      @(posedge clk_camera);
      if (chunk_tvalid !== 1'b0) begin
        mismatch_count++;
        $display("MISMATCH chunk_tvalid after reset: got %h expected 0", chunk_tvalid);
      end
      if (overflow !== 1'b0) begin
        mismatch_count++;
        $display("MISMATCH overflow after reset: got %h expected 0", overflow);
      end
    end

    send_frame(0);
    send_frame(1);  // counts restart on the second vsync
    ready_mode = READY_RANDOM;
    send_frame(2);
    send_frame(3);
    ready_mode = READY_HIGH;
    while (rx_chunks < CHECKED_FRAMES * CHUNKS_PER_FRAME) begin
      @(posedge clk_camera);
    end
    repeat (200) @(posedge clk_camera);
    if (rx_chunks != CHECKED_FRAMES * CHUNKS_PER_FRAME) begin
      fail_count++;
      $display("received %0d chunks, expected %0d", rx_chunks,
               CHECKED_FRAMES * CHUNKS_PER_FRAME);
    end
    if (overflow !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH overflow with a draining sink: got %h expected 0", overflow);
    end

    // sink stalled for a whole frame
    compare_en  = 1'b0;
    ready_mode  = READY_LOW;
    stall_watch = 1'b1;
    send_frame(4);
    if (overflow !== 1'b1) begin
      mismatch_count++;
      $display("MISMATCH overflow after stalled frame: got %h expected 1", overflow);
    end
    if (chunk_tvalid !== 1'b1) begin
      mismatch_count++;
      $display("MISMATCH chunk_tvalid after stalled frame: got %h expected 1", chunk_tvalid);
    end
    stall_watch = 1'b0;
    ready_mode  = READY_HIGH;
    while (chunk_tvalid) begin
      @(posedge clk_camera);
    end
    repeat (10) @(posedge clk_camera);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
